//--- hw/icache_cfg_pkg.sv
// instruction cache geometry and the vector types that follow from it
`default_nettype none

package icache_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_WIDTH  = 32;
  localparam int unsigned NUM_WAYS    = 4;
  localparam int unsigned NUM_SETS    = 64;
  localparam int unsigned LINE_WIDTH  = 128;
  localparam int unsigned FETCH_WIDTH = 32;

  // byte offset inside one line
  localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
  localparam int unsigned INDEX_WIDTH    = $clog2(NUM_SETS);
  // whatever is left above index and offset
  localparam int unsigned TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  // fetch words per line
  localparam int unsigned WORD_SEL_WIDTH = $clog2(LINE_WIDTH / FETCH_WIDTH);

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]       paddr_t;
  typedef logic [TAG_WIDTH-1:0]        tag_t;
  typedef logic [INDEX_WIDTH-1:0]      set_idx_t;
  typedef logic [WORD_SEL_WIDTH-1:0]   word_sel_t;
  typedef logic [LINE_WIDTH-1:0]       line_t;
  typedef logic [FETCH_WIDTH-1:0]      fetch_word_t;
  // one bit per way, used both as one-hot select and as write mask
  typedef logic [NUM_WAYS-1:0]         way_oh_t;
  typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;

endpackage

`default_nettype wire

//--- hw/icache_mem_pkg.sv
// memory-side protocol of the instruction cache: return packet kinds and region rule
`default_nettype none

package icache_mem_pkg;

  // packet kinds on the return port
  typedef enum logic {
    // line fill, or a single word for noncacheable fetches
    RTRN_IFILL = 1'b0,
    // clears one way or a whole set
    RTRN_INV   = 1'b1
  } rtrn_type_e;

  // upper half of the physical space is I/O, never cached
  localparam int unsigned NC_ADDR_BIT = 31;

  // a fetch bypasses the cache in the I/O half or while the cache is off
  function automatic logic is_noncacheable(
    input icache_cfg_pkg::paddr_t paddr,
    input logic                   cache_en
  );
    return paddr[NC_ADDR_BIT] | ~cache_en;
  endfunction

endpackage

`default_nettype wire

//--- hw/icache_arrays.sv
// instruction cache storage: a tag+valid bank and a data bank per way, read one cycle late
`default_nettype none
`timescale 1ns/10ps

module icache_arrays (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rd_en_i,
  input  logic                        wr_en_i,
  input  logic                        vld_we_i,
  input  icache_cfg_pkg::set_idx_t    idx_i,
  input  icache_cfg_pkg::way_oh_t     way_mask_i,
  input  logic                        vld_wdata_i,
  input  icache_cfg_pkg::tag_t        wtag_i,
  input  icache_cfg_pkg::line_t       wline_i,
  output icache_cfg_pkg::tag_t        rtag_o  [icache_cfg_pkg::NUM_WAYS],
  output icache_cfg_pkg::way_oh_t     rvld_o,
  output icache_cfg_pkg::line_t       rline_o [icache_cfg_pkg::NUM_WAYS]
);

  for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : gen_way
    // valid sits on top of the tag
    logic [icache_cfg_pkg::TAG_WIDTH:0] tag_mem [icache_cfg_pkg::NUM_SETS];
    icache_cfg_pkg::line_t              data_mem [icache_cfg_pkg::NUM_SETS];
    logic [icache_cfg_pkg::TAG_WIDTH:0] tag_rd_q;
    icache_cfg_pkg::line_t              line_rd_q;

    // valid writes also come from flush and invalidation, data only on fills
    always_ff @(posedge clk_i) begin
      if (vld_we_i && way_mask_i[w]) begin
        tag_mem[idx_i] <= {vld_wdata_i, wtag_i};
      end
      if (wr_en_i && way_mask_i[w]) begin
        data_mem[idx_i] <= wline_i;
      end
    end

    // read outputs hold until the next lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tag_rd_q <= '0;
      end else if (rd_en_i) begin
        tag_rd_q <= tag_mem[idx_i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
        line_rd_q <= data_mem[idx_i];
      end
    end

    assign rvld_o[w]  = tag_rd_q[icache_cfg_pkg::TAG_WIDTH];
    assign rtag_o[w]  = tag_rd_q[icache_cfg_pkg::TAG_WIDTH-1:0];
    assign rline_o[w] = line_rd_q;
  end

endmodule

`default_nettype wire

//--- hw/icache_hit_select.sv
// tag compare with lowest-way priority and fetch word select from cache or fill line
`default_nettype none
`timescale 1ns/10ps

module icache_hit_select (
  input  logic                        cmp_en_i,
  input  icache_cfg_pkg::tag_t        tag_i,
  input  icache_cfg_pkg::tag_t        rtag_i  [icache_cfg_pkg::NUM_WAYS],
  input  icache_cfg_pkg::way_oh_t     rvld_i,
  input  icache_cfg_pkg::line_t       rline_i [icache_cfg_pkg::NUM_WAYS],
  input  icache_cfg_pkg::line_t       fill_line_i,
  input  icache_cfg_pkg::word_sel_t   word_sel_i,
  output logic                        hit_o,
  output icache_cfg_pkg::fetch_word_t word_o
);

  icache_cfg_pkg::way_oh_t  hit_way;
  icache_cfg_pkg::way_idx_t hit_idx;
  icache_cfg_pkg::line_t    src_line;

  // per-way match
  for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : gen_cmp
    assign hit_way[w] = rvld_i[w] & (rtag_i[w] == tag_i);
  end

  // walk down so the lowest hitting way wins
  always_comb begin
    hit_idx = '0;
    for (int w = icache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_way[w]) begin
        hit_idx = icache_cfg_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit_o = cmp_en_i & (|hit_way);

  // no compare means the word comes from the return port,
  // noncacheable words already sit at their own position
  assign src_line = cmp_en_i ? rline_i[hit_idx] : fill_line_i;
  assign word_o   = src_line[word_sel_i * icache_cfg_pkg::FETCH_WIDTH +:
                             icache_cfg_pkg::FETCH_WIDTH];

endmodule

`default_nettype wire

//--- hw/icache_victim_select.sv
// refill victim choice: first invalid way, else an LFSR pick once the set is full
`default_nettype none
`timescale 1ns/10ps

module icache_victim_select (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  icache_cfg_pkg::way_oh_t     rvld_i,
  input  logic                        cmp_en_i,
  input  logic                        fill_i,
  output icache_cfg_pkg::way_idx_t    victim_way_o,
  output icache_cfg_pkg::way_oh_t     victim_oh_o
);

  logic [7:0]               lfsr_q;
  logic                     lfsr_fb;
  logic                     all_valid;
  icache_cfg_pkg::way_idx_t inv_way;
  icache_cfg_pkg::way_oh_t  victim_oh_q;

  // lowest free way
  always_comb begin
    inv_way = '0;
    for (int w = icache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!rvld_i[w]) begin
        inv_way = icache_cfg_pkg::way_idx_t'(w);
      end
    end
  end

  assign all_valid    = &rvld_i;
  assign victim_way_o = all_valid ? icache_cfg_pkg::way_idx_t'(lfsr_q) : inv_way;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // any nonzero seed
      lfsr_q      <= 8'hA5;
      victim_oh_q <= '0;
    end else begin
      // step only when a full set actually got a line replaced
      if (fill_i && all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
      // capture during the compare cycle, used by the later fill write
      if (cmp_en_i) begin
        victim_oh_q <= icache_cfg_pkg::way_oh_t'(1) << victim_way_o;
      end
    end
  end

  assign victim_oh_o = victim_oh_q;

endmodule

`default_nettype wire

//--- hw/icache_ctrl.sv
// instruction cache controller: fetch FSM, refill requests, flush sweep and invalidations
`default_nettype none
`timescale 1ns/10ps

module icache_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic                             flush_i,
  // fetch side
  input  logic                             req_i,
  input  icache_cfg_pkg::paddr_t           addr_i,
  output logic                             ready_o,
  output logic                             valid_o,
  output icache_cfg_pkg::fetch_word_t      data_o,
  output logic                             busy_o,
  output logic                             miss_o,
  // refill request
  output logic                             mem_req_o,
  input  logic                             mem_ack_i,
  output icache_cfg_pkg::paddr_t           mem_paddr_o,
  output logic                             mem_nc_o,
  output icache_cfg_pkg::way_idx_t         mem_way_o,
  // return port
  input  logic                             mem_rtrn_vld_i,
  input  icache_mem_pkg::rtrn_type_e       mem_rtrn_type_i,
  input  icache_cfg_pkg::set_idx_t         mem_inv_idx_i,
  input  icache_cfg_pkg::way_idx_t         mem_inv_way_i,
  input  logic                             mem_inv_all_i,
  // datapath
  input  logic                             hit_i,
  input  icache_cfg_pkg::fetch_word_t      hit_word_i,
  input  icache_cfg_pkg::way_idx_t         victim_way_i,
  input  icache_cfg_pkg::way_oh_t          victim_oh_i,
  output logic                             rd_en_o,
  output logic                             wr_en_o,
  output logic                             vld_we_o,
  output logic                             cmp_en_o,
  output icache_cfg_pkg::set_idx_t         rd_idx_o,
  output icache_cfg_pkg::way_oh_t          vld_mask_o,
  output logic                             vld_wdata_o,
  output icache_cfg_pkg::tag_t             lookup_tag_o,
  output icache_cfg_pkg::word_sel_t        word_sel_o
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e                   state_d, state_q;
  icache_cfg_pkg::paddr_t   addr_d, addr_q;
  icache_cfg_pkg::set_idx_t flush_cnt_d, flush_cnt_q;
  icache_cfg_pkg::set_idx_t fetch_idx;
  logic                     nc_d, nc_q;
  logic                     cmp_en_d, cmp_en_q;
  logic                     cache_en_d, cache_en_q;
  logic                     flush_d, flush_q;
  logic                     flush_pend;
  logic                     flush_en, flush_done;
  logic                     inv_en, inv_q;
  logic                     fill_rtrn, fill_we;
  logic                     lookup_hit, accept;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and request bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  assign inv_en    = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_mem_pkg::RTRN_INV);
  assign fill_rtrn = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_mem_pkg::RTRN_IFILL);

  // a flush is owed on request, or when the cache is being switched on
  assign flush_pend = flush_q | flush_i | (en_i & ~cache_en_q);

  // stale compare right after an invalidation is never trusted as a hit
  assign lookup_hit = (state_q == READ) & hit_i & ~inv_q;

  // returns share the array port, so no lookup starts while one is present
  assign ready_o = ((state_q == IDLE) | lookup_hit) & ~mem_rtrn_vld_i & ~flush_pend;
  assign accept  = req_i & ready_o;

  assign addr_d = accept ? addr_i : addr_q;
  // disable takes effect at once, en_i is sampled along with cache_en_q
  assign nc_d   = accept ? icache_mem_pkg::is_noncacheable(addr_i, cache_en_q & en_i) : nc_q;

  // sweep counter wraps back to set 0 on its last step
  assign flush_done  = (flush_cnt_q == icache_cfg_pkg::set_idx_t'(icache_cfg_pkg::NUM_SETS - 1));
  assign flush_cnt_d = flush_done ? '0 :
                       flush_en   ? icache_cfg_pkg::set_idx_t'(flush_cnt_q + 1'b1) :
                                    flush_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    cmp_en_d   = 1'b0;
    flush_en   = 1'b0;
    fill_we    = 1'b0;
    valid_o    = 1'b0;
    mem_req_o  = 1'b0;
    miss_o     = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = flush_i;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_pend) begin
          state_d = FLUSH;
        end else if (accept) begin
          state_d = READ;
        end
      end
      // tags and data are out of the arrays now
      READ: begin
        if (lookup_hit) begin
          valid_o = 1'b1;
          state_d = accept ? READ : IDLE;
        end else begin
          // miss or noncacheable, hold the request until it is taken
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      // fill is consumed in the cycle it shows up
      MISS: begin
        if (fill_rtrn) begin
          valid_o = 1'b1;
          fill_we = ~nc_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase

    // compare only what could have been cached
    if (accept) begin
      cmp_en_d = ~nc_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // array control
  ////////////////////////////////////////////////////////////////////////////

  // refill writes the latched set, a new lookup reads the incoming one
  assign fetch_idx = (state_q == MISS) ?
                     addr_q[icache_cfg_pkg::OFFSET_WIDTH +: icache_cfg_pkg::INDEX_WIDTH] :
                     addr_i[icache_cfg_pkg::OFFSET_WIDTH +: icache_cfg_pkg::INDEX_WIDTH];

  // sweep first, then invalidation; neither overlaps a lookup or a fill
  assign rd_idx_o   = flush_en ? flush_cnt_q :
                      inv_en   ? mem_inv_idx_i :
                                 fetch_idx;
  assign vld_mask_o = flush_en      ? '1 :
                      !inv_en       ? victim_oh_i :
                      mem_inv_all_i ? '1 :
                                      icache_cfg_pkg::way_oh_t'(1) << mem_inv_way_i;

  assign rd_en_o     = accept;
  assign wr_en_o     = fill_we;
  assign vld_we_o    = flush_en | inv_en | fill_we;
  assign vld_wdata_o = fill_we;
  assign cmp_en_o    = cmp_en_q;

  assign lookup_tag_o = addr_q[icache_cfg_pkg::ADDR_WIDTH-1 -: icache_cfg_pkg::TAG_WIDTH];
  assign word_sel_o   = addr_q[icache_cfg_pkg::OFFSET_WIDTH-1 -: icache_cfg_pkg::WORD_SEL_WIDTH];

  // word address for I/O fetches, line address otherwise
  assign mem_paddr_o = nc_q ?
    {addr_q[icache_cfg_pkg::ADDR_WIDTH-1:2], 2'b00} :
    {addr_q[icache_cfg_pkg::ADDR_WIDTH-1:icache_cfg_pkg::OFFSET_WIDTH],
     {icache_cfg_pkg::OFFSET_WIDTH{1'b0}}};
  assign mem_nc_o  = nc_q;
  assign mem_way_o = victim_way_i;

  assign data_o = hit_word_i;
  assign busy_o = (state_q != IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_cnt_q <= '0;
      cmp_en_q    <= 1'b0;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      inv_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_cnt_q <= flush_cnt_d;
      cmp_en_q    <= cmp_en_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      inv_q       <= inv_en;
    end
  end

  // request address and its region
  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    nc_q   <= nc_d;
  end

endmodule

`default_nettype wire

//--- hw/icache_top.sv
// four-way physically addressed instruction cache with single-cycle line refills
`default_nettype none
`timescale 1ns/10ps

module icache_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic                             flush_i,
  // fetch side
  input  logic                             req_i,
  input  icache_cfg_pkg::paddr_t           addr_i,
  output logic                             ready_o,
  output logic                             valid_o,
  output logic                             busy_o,
  output logic                             miss_o,
  output icache_cfg_pkg::fetch_word_t      data_o,
  // refill request
  output logic                             mem_req_o,
  input  logic                             mem_ack_i,
  output icache_cfg_pkg::paddr_t           mem_paddr_o,
  output logic                             mem_nc_o,
  output icache_cfg_pkg::way_idx_t         mem_way_o,
  // return port
  input  logic                             mem_rtrn_vld_i,
  input  icache_mem_pkg::rtrn_type_e       mem_rtrn_type_i,
  input  icache_cfg_pkg::line_t            mem_rtrn_data_i,
  input  icache_cfg_pkg::set_idx_t         mem_inv_idx_i,
  input  icache_cfg_pkg::way_idx_t         mem_inv_way_i,
  input  logic                             mem_inv_all_i
);

  logic                        hit;
  icache_cfg_pkg::fetch_word_t hit_word;
  icache_cfg_pkg::way_idx_t    victim_way;
  icache_cfg_pkg::way_oh_t     victim_oh;
  logic                        rd_en, wr_en, vld_we, cmp_en, vld_wdata;
  icache_cfg_pkg::set_idx_t    rd_idx;
  icache_cfg_pkg::way_oh_t     vld_mask;
  icache_cfg_pkg::tag_t        lookup_tag;
  icache_cfg_pkg::word_sel_t   word_sel;
  icache_cfg_pkg::tag_t        rtag  [icache_cfg_pkg::NUM_WAYS];
  icache_cfg_pkg::way_oh_t     rvld;
  icache_cfg_pkg::line_t       rline [icache_cfg_pkg::NUM_WAYS];

  icache_ctrl i_ctrl (
    .clk_i, .rst_ni, .en_i, .flush_i,
    .req_i, .addr_i, .ready_o, .valid_o, .data_o, .busy_o, .miss_o,
    .mem_req_o, .mem_ack_i, .mem_paddr_o, .mem_nc_o, .mem_way_o,
    .mem_rtrn_vld_i, .mem_rtrn_type_i, .mem_inv_idx_i, .mem_inv_way_i, .mem_inv_all_i,
    .hit_i        ( hit        ),
    .hit_word_i   ( hit_word   ),
    .victim_way_i ( victim_way ),
    .victim_oh_i  ( victim_oh  ),
    .rd_en_o      ( rd_en      ),
    .wr_en_o      ( wr_en      ),
    .vld_we_o     ( vld_we     ),
    .cmp_en_o     ( cmp_en     ),
    .rd_idx_o     ( rd_idx     ),
    .vld_mask_o   ( vld_mask   ),
    .vld_wdata_o  ( vld_wdata  ),
    .lookup_tag_o ( lookup_tag ),
    .word_sel_o   ( word_sel   )
  );

  // the latched tag serves both the compare and the fill write
  icache_arrays i_arrays (
    .clk_i, .rst_ni,
    .rd_en_i     ( rd_en           ),
    .wr_en_i     ( wr_en           ),
    .vld_we_i    ( vld_we          ),
    .idx_i       ( rd_idx          ),
    .way_mask_i  ( vld_mask        ),
    .vld_wdata_i ( vld_wdata       ),
    .wtag_i      ( lookup_tag      ),
    .wline_i     ( mem_rtrn_data_i ),
    .rtag_o      ( rtag            ),
    .rvld_o      ( rvld            ),
    .rline_o     ( rline           )
  );

  icache_hit_select i_hit_select (
    .cmp_en_i    ( cmp_en          ),
    .tag_i       ( lookup_tag      ),
    .rtag_i      ( rtag            ),
    .rvld_i      ( rvld            ),
    .rline_i     ( rline           ),
    .fill_line_i ( mem_rtrn_data_i ),
    .word_sel_i  ( word_sel        ),
    .hit_o       ( hit             ),
    .word_o      ( hit_word        )
  );

  icache_victim_select i_victim_select (
    .clk_i, .rst_ni,
    .rvld_i       ( rvld       ),
    .cmp_en_i     ( cmp_en     ),
    .fill_i       ( wr_en      ),
    .victim_way_o ( victim_way ),
    .victim_oh_o  ( victim_oh  )
  );

endmodule

`default_nettype wire

//--- tb/tb_icache_model.svh
// instruction cache testbench model with the memory data rule, expected request fields and compares
`ifndef TB_ICACHE_MODEL_SVH
`define TB_ICACHE_MODEL_SVH

  // every memory word holds its own word address scrambled by this key
  localparam icache_cfg_pkg::fetch_word_t DATA_KEY = 32'hA5C3_0F1E;

  int unsigned check_cnt;
  int unsigned mismatch_cnt;
  int unsigned timeout_cnt;

  function automatic icache_cfg_pkg::fetch_word_t data_rule(input icache_cfg_pkg::paddr_t a);
    return {a[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  function automatic icache_cfg_pkg::paddr_t word_base(input icache_cfg_pkg::paddr_t a);
    return {a[31:2], 2'b00};
  endfunction

  function automatic icache_cfg_pkg::paddr_t line_base(input icache_cfg_pkg::paddr_t a);
    return (a >> icache_cfg_pkg::OFFSET_WIDTH) << icache_cfg_pkg::OFFSET_WIDTH;
  endfunction

  // whole line around a with the lowest word in the low bits
  function automatic icache_cfg_pkg::line_t build_line(input icache_cfg_pkg::paddr_t a);
    icache_cfg_pkg::line_t  line;
    icache_cfg_pkg::paddr_t base;
    base = line_base(a);
    for (int unsigned i = 0; i < icache_cfg_pkg::LINE_WIDTH / icache_cfg_pkg::FETCH_WIDTH;
         i++) begin
      line[i*icache_cfg_pkg::FETCH_WIDTH +: icache_cfg_pkg::FETCH_WIDTH] =
        data_rule(base + icache_cfg_pkg::paddr_t'(4 * i));
    end
    return line;
  endfunction

  // upper half of the address space or cache switched off
  function automatic logic expect_nc(input icache_cfg_pkg::paddr_t a, input logic en);
    return a[icache_mem_pkg::NC_ADDR_BIT] || !en;
  endfunction

  task automatic check_word(input string name, input icache_cfg_pkg::fetch_word_t exp,
                            input icache_cfg_pkg::fetch_word_t act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input icache_cfg_pkg::paddr_t exp,
                            input icache_cfg_pkg::paddr_t act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_way(input string name, input icache_cfg_pkg::way_idx_t exp,
                           input icache_cfg_pkg::way_idx_t act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

`endif

//--- tb/tb_icache.sv
// testbench for the instruction cache with directed and random fetches against a memory model
`default_nettype none
`timescale 1ns/10ps

module tb_icache;

  localparam int unsigned MAX_WAIT = 200;
  localparam int unsigned MIX_LEN  = 300;

  logic                        clk_i, rst_ni, en_i, flush_i, req_i;
  icache_cfg_pkg::paddr_t      addr_i;
  logic                        ready_o, valid_o, busy_o, miss_o;
  icache_cfg_pkg::fetch_word_t data_o;
  logic                        mem_req_o, mem_ack_i, mem_nc_o;
  icache_cfg_pkg::paddr_t      mem_paddr_o;
  icache_cfg_pkg::way_idx_t    mem_way_o;
  logic                        mem_rtrn_vld_i;
  icache_mem_pkg::rtrn_type_e  mem_rtrn_type_i;
  icache_cfg_pkg::line_t       mem_rtrn_data_i;
  icache_cfg_pkg::set_idx_t    mem_inv_idx_i;
  icache_cfg_pkg::way_idx_t    mem_inv_way_i;
  logic                        mem_inv_all_i;
  integer                      seed;
  icache_cfg_pkg::paddr_t      pool [8];

  `include "tb_icache_model.svh"

  icache_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_counts();
    $display("checks %0d, mismatches %0d, timeouts %0d", check_cnt, mismatch_cnt, timeout_cnt);
  endtask

  task automatic give_up(input string what);
    timeout_cnt++;
    $display("ERROR: timed out waiting for %s", what);
    report_counts();
    $display("Test failures found");
    $finish;
  endtask

  // request held high until the cache takes it
  task automatic wait_ready();
    int unsigned n;
    n = 0;
    while (!ready_o) begin
      if (n == MAX_WAIT) begin
        give_up("ready_o");
      end
      n++;
      @(negedge clk_i);
      #1;
    end
  endtask

  // one fetch with the memory side answered in line
  task automatic fetch(input icache_cfg_pkg::paddr_t a, input string name,
                       output logic hit, output logic missed,
                       output icache_cfg_pkg::way_idx_t way);
    logic        nc;
    int unsigned delay;
    @(negedge clk_i);
    req_i  = 1'b1;
    addr_i = a;
    #1;
    wait_ready();
    nc = expect_nc(a, en_i);
    @(negedge clk_i);
    req_i = 1'b0;
    #1;
    hit    = valid_o;
    missed = 1'b0;
    way    = mem_way_o;
    if (hit) begin
      check_bit({name, " hit on bypass"}, 1'b0, nc);
      check_bit({name, " req"}, 1'b0, mem_req_o);
      check_bit({name, " miss"}, 1'b0, miss_o);
      check_word({name, " data"}, data_rule(a), data_o);
    end else begin
      check_bit({name, " req"}, 1'b1, mem_req_o);
      check_bit({name, " nc"}, nc, mem_nc_o);
      check_addr({name, " paddr"}, nc ? word_base(a) : line_base(a), mem_paddr_o);
      // memory takes 1 to 6 cycles to accept
      delay = 1 + ($unsigned($random(seed)) % 6);
      repeat (delay - 1) begin
        @(negedge clk_i);
        #1;
        check_bit({name, " req held"}, 1'b1, mem_req_o);
      end
      @(negedge clk_i);
      mem_ack_i = 1'b1;
      #1;
      missed = miss_o;
      check_bit({name, " miss"}, ~nc, miss_o);
      @(negedge clk_i);
      mem_ack_i = 1'b0;
      repeat ($unsigned($random(seed)) % 3) @(negedge clk_i);
      mem_rtrn_vld_i  = 1'b1;
      mem_rtrn_type_i = icache_mem_pkg::RTRN_IFILL;
      mem_rtrn_data_i = build_line(mem_paddr_o);
      #1;
      check_bit({name, " fill valid"}, 1'b1, valid_o);
      check_word({name, " fill data"}, data_rule(a), data_o);
      @(negedge clk_i);
      mem_rtrn_vld_i = 1'b0;
    end
  endtask

  task automatic send_inv(input icache_cfg_pkg::paddr_t a, input logic all,
                          input icache_cfg_pkg::way_idx_t way);
    @(negedge clk_i);
    mem_rtrn_vld_i  = 1'b1;
    mem_rtrn_type_i = icache_mem_pkg::RTRN_INV;
    mem_inv_idx_i   = a[icache_cfg_pkg::OFFSET_WIDTH +: icache_cfg_pkg::INDEX_WIDTH];
    mem_inv_way_i   = way;
    mem_inv_all_i   = all;
    @(negedge clk_i);
    mem_rtrn_vld_i  = 1'b0;
  endtask

  task automatic pulse_flush();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic                     hit, missed;
    logic [31:0]              r;
    icache_cfg_pkg::paddr_t   a;
    icache_cfg_pkg::way_idx_t way;
    seed            = 32'h7689abe6;
    check_cnt       = 0;
    mismatch_cnt    = 0;
    timeout_cnt     = 0;
    rst_ni          = 1'b0;
    en_i            = 1'b1;
    flush_i         = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = icache_mem_pkg::RTRN_IFILL;
    mem_rtrn_data_i = '0;
    mem_inv_idx_i   = '0;
    mem_inv_way_i   = '0;
    mem_inv_all_i   = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;

    // sweep after reset takes exactly one cycle per set
    for (int unsigned i = 0; i < icache_cfg_pkg::NUM_SETS; i++) begin
      check_bit("reset busy", 1'b1, busy_o);
      check_bit("reset ready", 1'b0, ready_o);
      @(negedge clk_i);
      #1;
    end
    check_bit("sweep end busy", 1'b0, busy_o);

    // fill and then hit the same line again
    fetch(32'h0000_1230, "first fill", hit, missed, way);
    check_bit("first fill hit", 1'b0, hit);
    // an empty set takes its lowest way first
    check_way("first fill way", '0, way);
    fetch(32'h0000_1234, "refetch", hit, missed, way);
    check_bit("refetch hit", 1'b1, hit);
    // second tag in the same set goes to the next free way
    fetch(32'h0000_5230, "second tag", hit, missed, way);
    check_bit("second tag miss", 1'b1, missed);
    check_way("second tag way", icache_cfg_pkg::way_idx_t'(1), way);

    // I/O half is never cached
    fetch(32'h8000_0108, "io", hit, missed, way);
    check_bit("io hit", 1'b0, hit);
    fetch(32'h8000_0108, "io again", hit, missed, way);
    check_bit("io again hit", 1'b0, hit);

    // with the cache off even a filled line goes to memory
    @(negedge clk_i);
    en_i = 1'b0;
    fetch(32'h0000_1230, "disabled", hit, missed, way);
    check_bit("disabled hit", 1'b0, hit);
    fetch(32'h0000_1230, "disabled again", hit, missed, way);
    check_bit("disabled again hit", 1'b0, hit);
    @(negedge clk_i);
    en_i = 1'b1;
    // switching on flushes so the line is gone
    fetch(32'h0000_1230, "re-enabled", hit, missed, way);
    check_bit("re-enabled miss", 1'b1, missed);
    check_way("re-enabled way", '0, way);
    fetch(32'h0000_1230, "re-enabled refetch", hit, missed, way);
    check_bit("re-enabled refetch hit", 1'b1, hit);

    // explicit flush
    pulse_flush();
    fetch(32'h0000_1230, "after flush", hit, missed, way);
    check_bit("after flush miss", 1'b1, missed);
    check_way("after flush way", '0, way);

    // whole-set invalidation
    fetch(32'h0004_5678, "inv fill", hit, missed, way);
    fetch(32'h0004_5678, "inv refetch", hit, missed, way);
    check_bit("inv refetch hit", 1'b1, hit);
    send_inv(32'h0004_5678, 1'b1, '0);
    fetch(32'h0004_5678, "after inv", hit, missed, way);
    check_bit("after inv miss", 1'b1, missed);
    check_way("after inv way", '0, way);

    // random mix over a few sets with more tags than ways
    for (int unsigned i = 0; i < 8; i++) begin
      pool[i] = icache_cfg_pkg::paddr_t'($random(seed)) & 32'h8000_7010;
    end
    for (int unsigned i = 0; i < MIX_LEN; i++) begin
      r = $random(seed);
      a = pool[r[2:0]] | {28'h0, r[5:4], 2'b00};
      if (r[9:6] == 4'd0) begin
        send_inv(a, r[10], r[12:11]);
      end else if (r[9:6] == 4'd1) begin
        pulse_flush();
      end else if (r[20:17] == 4'd0) begin
        @(negedge clk_i);
        en_i = ~en_i;
      end else begin
        fetch(a, "mix", hit, missed, way);
      end
    end

    report_counts();
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icache_lite.f
+incdir+tb
hw/icache_cfg_pkg.sv
hw/icache_mem_pkg.sv
hw/icache_arrays.sv
hw/icache_hit_select.sv
hw/icache_victim_select.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/tb_icache.sv

//--- run_sim.sh
#!/bin/sh
# build the instruction cache testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_icache \
  -f icache_lite.f -o tb_icache \
  && ./obj_dir/tb_icache | tee sim.log
grep -q 'All tests passed!' sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
